// File: logic/hand_seg_pkg.sv
// shared geometry, register map and bus/pixel types for the hand segmentation engine
`default_nettype none

package hand_seg_pkg;

  // frame geometry
  localparam int img_w  = 32;
  localparam int img_h  = 24;
  localparam int n_pix  = img_w * img_h;
  localparam int addr_w = $clog2(n_pix);  // 10 bits
  localparam int acc_w  = 18;             // 768 * 255 fits
  localparam int cnt_w  = 10;

  // chroma window, inclusive bounds
  localparam logic [7:0] cb_lo   = 8'd90;
  localparam logic [7:0] cb_hi   = 8'd120;
  localparam logic [7:0] cr_lo   = 8'd139;
  localparam logic [7:0] cr_hi   = 8'd170;
  localparam logic [7:0] mask_on = 8'd255;

  // APB register map, byte addresses
  localparam int paddr_w = 13;
  localparam logic [paddr_w-1:0] frame_end  = paddr_w'(n_pix * 4);  // first byte past the frame
  localparam logic [paddr_w-1:0] reg_ctrl   = 13'h1000;
  localparam logic [paddr_w-1:0] reg_status = 13'h1004;
  localparam logic [paddr_w-1:0] reg_area   = 13'h1008;
  localparam logic [paddr_w-1:0] reg_perim  = 13'h100C;
  localparam logic [paddr_w-1:0] reg_means  = 13'h1010;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  typedef logic [addr_w-1:0] pix_addr_t;
  typedef logic [cnt_w-1:0]  count_t;

  typedef struct packed {
    logic [7:0] max_mean;  // top byte
    logic [7:0] b;
    logic [7:0] g;
    logic [7:0] r;         // low byte
  } means_t;

  typedef struct packed {
    logic [paddr_w-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic      we;
    pix_addr_t addr;
    pixel_t    data;
  } ram_wr_t;

  typedef enum logic [2:0] {
    pass_idle,
    pass_mean,
    pass_comp,
    pass_seg,
    pass_meas
  } pass_t;

  typedef struct packed {
    count_t area;
    count_t perim;
    means_t means;
  } results_t;

endpackage

`default_nettype wire

// File: logic/frame_ram.sv
// on-chip RGB frame buffer, one registered read port and one write port, shared via the arbiter
`timescale 1ns/1ps
`default_nettype none

module frame_ram (
  input  logic                    clk,
  input  hand_seg_pkg::pix_addr_t rd_addr,
  output hand_seg_pkg::pixel_t    rd_data,
  input  hand_seg_pkg::ram_wr_t   wr
);
  import hand_seg_pkg::*;

  pixel_t mem [n_pix];

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // read-during-write to the same word returns the old pixel
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: logic/ram_arbiter.sv
// hands the frame buffer ports to the engine while busy and to the APB host otherwise
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    busy,
  input  hand_seg_pkg::pix_addr_t eng_rd_addr,
  input  hand_seg_pkg::ram_wr_t   eng_wr,
  input  logic                    host_rd,
  input  hand_seg_pkg::pix_addr_t host_rd_addr,
  input  hand_seg_pkg::ram_wr_t   host_wr,
  output logic                    host_gnt,
  output logic                    host_rvalid,
  output hand_seg_pkg::pixel_t    host_rd_data,
  output hand_seg_pkg::pix_addr_t ram_rd_addr,
  output hand_seg_pkg::ram_wr_t   ram_wr,
  input  hand_seg_pkg::pixel_t    ram_rd_data
);
  import hand_seg_pkg::*;

  assign host_gnt = !busy;

  assign ram_rd_addr = busy ? eng_rd_addr : host_rd_addr;

  always_comb begin
    if (busy) begin
      ram_wr = eng_wr;  // host write dropped
    end else begin
      ram_wr = host_wr;
    end
  end

  // data of a granted host read lands one cycle later
  always_ff @(posedge clk) begin
    if (!rst) begin
      host_rvalid <= 1'b0;
    end else begin
      host_rvalid <= host_rd && host_gnt;
    end
  end

  assign host_rd_data = ram_rd_data;

endmodule

`default_nettype wire

// File: logic/apb_regs.sv
// APB slave for the engine: frame window, control/status and result registers
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  hand_seg_pkg::apb_req_t  apb_req,
  output hand_seg_pkg::apb_rsp_t  apb_rsp,
  output logic                    start,
  input  logic                    busy,
  input  logic                    done,
  input  hand_seg_pkg::results_t  results,
  output logic                    host_rd,
  output hand_seg_pkg::pix_addr_t host_rd_addr,
  output hand_seg_pkg::ram_wr_t   host_wr,
  input  logic                    host_gnt,
  input  logic                    host_rvalid,
  input  hand_seg_pkg::pixel_t    host_rd_data
);
  import hand_seg_pkg::*;

  logic        access;
  logic        in_frame;
  logic        reg_hit;
  logic        pready;
  logic [31:0] rdata;

  assign access   = apb_req.psel && apb_req.penable;
  assign in_frame = apb_req.paddr < frame_end;
  assign reg_hit  = apb_req.paddr inside {reg_ctrl, reg_status, reg_area, reg_perim, reg_means};

  // frame window, pixel index is byte address / 4
  assign host_rd_addr = apb_req.paddr[addr_w+1:2];
  assign host_rd      = access && !apb_req.pwrite && in_frame && !host_rvalid;
  assign host_wr      = '{we:   access && apb_req.pwrite && in_frame && host_gnt,
                          addr: apb_req.paddr[addr_w+1:2],
                          data: pixel_t'(apb_req.pwdata[23:0])};

  always_comb begin
    pready = 1'b0;
    if (access) begin
      if (!in_frame) begin
        pready = 1'b1;              // registers and unmapped, no wait
      end else if (apb_req.pwrite) begin
        pready = host_gnt;
      end else begin
        pready = host_rvalid;
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (in_frame) begin
      rdata = 32'(host_rd_data);
    end else begin
      case (apb_req.paddr)
        reg_status: rdata = {30'd0, done, busy};
        reg_area:   rdata = 32'(results.area);
        reg_perim:  rdata = 32'(results.perim);
        reg_means:  rdata = results.means;
        default:    rdata = '0;
      endcase
    end
  end

  assign apb_rsp = '{prdata: rdata, pready: pready, pslverr: access && !(in_frame || reg_hit)};

  // run request ignored while the engine is working
  always_ff @(posedge clk) begin
    if (!rst) begin
      start <= 1'b0;
    end else begin
      start <= access && apb_req.pwrite && (apb_req.paddr == reg_ctrl) &&
               apb_req.pwdata[0] && !busy && !start;
    end
  end

endmodule

`default_nettype wire

// File: logic/pass_sequencer.sv
// pass FSM of the engine: raster read addresses per pass and the write-back pipeline strobes
`timescale 1ns/1ps
`default_nettype none

module pass_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  output logic                    busy,
  output logic                    done,
  output hand_seg_pkg::pass_t     pass,
  output hand_seg_pkg::pix_addr_t rd_addr,
  output logic                    pix_valid,
  output hand_seg_pkg::pix_addr_t wb_addr,
  output logic                    mean_calc
);
  import hand_seg_pkg::*;

  pix_addr_t step;      // position in the pass, reads then drain
  logic      rd_en;
  logic      pass_end;

  assign rd_en   = busy && (step < pix_addr_t'(n_pix));
  assign rd_addr = rd_en ? step : '0;

  // mean pass gets one extra cycle for the divide
  assign mean_calc = (pass == pass_mean) && (step == pix_addr_t'(n_pix + 2));
  assign pass_end  = (pass == pass_mean) ? mean_calc
                                         : (step == pix_addr_t'(n_pix + 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      pass <= pass_idle;
      step <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end else if (pass == pass_idle) begin
      if (start) begin
        pass <= pass_mean;
        step <= '0;
        busy <= 1'b1;
        done <= 1'b0;
      end
    end else if (pass_end) begin
      step <= '0;
      case (pass)
        pass_mean: pass <= pass_comp;
        pass_comp: pass <= pass_seg;
        pass_seg:  pass <= pass_meas;
        default: begin       // measurement drained
          pass <= pass_idle;
          busy <= 1'b0;
          done <= 1'b1;
        end
      endcase
    end else begin
      step <= step + 1'b1;
    end
  end

  // read at t, data valid at t+1
  always_ff @(posedge clk) begin
    if (!rst) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= rd_addr;
  end

endmodule

`default_nettype wire

// File: logic/pixel_ops.sv
// per-pass pixel math: channel means, compensation, chroma mask, area and perimeter
`timescale 1ns/1ps
`default_nettype none

module pixel_ops (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  hand_seg_pkg::pass_t     pass,
  input  logic                    pix_valid,
  input  hand_seg_pkg::pix_addr_t wb_addr,
  input  logic                    mean_calc,
  input  hand_seg_pkg::pixel_t    rd_data,
  output hand_seg_pkg::ram_wr_t   wr,
  output hand_seg_pkg::results_t  results
);
  import hand_seg_pkg::*;

  logic [acc_w-1:0]   acc_r, acc_g, acc_b;
  means_t             means;
  count_t             area, perim;
  logic [7:0]         prev_red;
  logic [7:0]         div_r, div_g, div_b, div_max;
  logic signed [17:0] r_s, g_s, b_s;
  logic signed [17:0] cb_full, cr_full;
  logic               in_window;
  pixel_t             comp_px, mask_px;
  logic               wr_we;
  pix_addr_t          wr_addr;
  pixel_t             wr_data;

  // v * m / mx, truncating, 0 when the max mean is 0
  function automatic logic [7:0] scale(input logic [7:0] v, input logic [7:0] m,
                                       input logic [7:0] mx);
    logic [15:0] prod;
    prod = v * m;
    if (mx == 8'd0) return 8'd0;
    return 8'(prod / mx);
  endfunction

  assign div_r = 8'(acc_r / n_pix);
  assign div_g = 8'(acc_g / n_pix);
  assign div_b = 8'(acc_b / n_pix);

  always_comb begin
    div_max = div_r;
    if (div_g > div_max) div_max = div_g;
    if (div_b > div_max) div_max = div_b;
  end

  assign comp_px = '{r: scale(rd_data.r, means.r, means.max_mean),
                     g: scale(rd_data.g, means.g, means.max_mean),
                     b: scale(rd_data.b, means.b, means.max_mean)};

  assign r_s = $signed({10'd0, rd_data.r});
  assign g_s = $signed({10'd0, rd_data.g});
  assign b_s = $signed({10'd0, rd_data.b});

  // chroma, 8-bit fixed point coefficients
  assign cb_full = ((18'sd112 * b_s - 18'sd38 * r_s - 18'sd74 * g_s) >>> 8) + 18'sd128;
  assign cr_full = ((18'sd112 * r_s - 18'sd94 * g_s - 18'sd18 * b_s) >>> 8) + 18'sd128;

  assign in_window = (cb_full[7:0] >= cb_lo) && (cb_full[7:0] <= cb_hi) &&
                     (cr_full[7:0] >= cr_lo) && (cr_full[7:0] <= cr_hi);
  assign mask_px   = in_window ? '{r: mask_on, g: mask_on, b: mask_on} : '0;

  always_ff @(posedge clk) begin
    if (!rst || start) begin
      acc_r    <= '0;
      acc_g    <= '0;
      acc_b    <= '0;
      means    <= '0;
      area     <= '0;
      perim    <= '0;
      prev_red <= '0;
    end else begin
      if (pix_valid && pass == pass_mean) begin
        acc_r <= acc_r + rd_data.r;
        acc_g <= acc_g + rd_data.g;
        acc_b <= acc_b + rd_data.b;
      end
      if (mean_calc) begin
        means <= '{max_mean: div_max, b: div_b, g: div_g, r: div_r};
      end
      if (pix_valid && pass == pass_meas) begin
        if (rd_data != '0) area <= area + 1'b1;
        if (rd_data.r != prev_red) perim <= perim + 1'b1;  // edge in raster order
        prev_red <= rd_data.r;
      end
    end
  end

  // write back two cycles after the read
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_we <= 1'b0;
    end else begin
      wr_we <= pix_valid && (pass == pass_comp || pass == pass_seg);
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= wb_addr;
    wr_data <= (pass == pass_comp) ? comp_px : mask_px;
  end

  assign wr      = '{we: wr_we, addr: wr_addr, data: wr_data};
  assign results = '{area: area, perim: perim, means: means};

endmodule

`default_nettype wire

// File: logic/hand_seg_top.sv
// top of the hand segmentation engine, APB slave in front of the shared frame buffer
`timescale 1ns/1ps
`default_nettype none

module hand_seg_top (
  input  logic                   clk,
  input  logic                   rst,
  input  hand_seg_pkg::apb_req_t apb_req,
  output hand_seg_pkg::apb_rsp_t apb_rsp
);
  import hand_seg_pkg::*;

  logic      start, busy, done;
  results_t  results;
  logic      host_rd, host_gnt, host_rvalid;
  pix_addr_t host_rd_addr;
  ram_wr_t   host_wr;
  pixel_t    host_rd_data;
  pix_addr_t eng_rd_addr, ram_rd_addr, wb_addr;
  ram_wr_t   eng_wr, ram_wr;
  pixel_t    ram_rd_data;
  pass_t     pass;
  logic      pix_valid, mean_calc;

  apb_regs apb_regs_i (
    .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .start(start), .busy(busy), .done(done), .results(results),
    .host_rd(host_rd), .host_rd_addr(host_rd_addr), .host_wr(host_wr),
    .host_gnt(host_gnt), .host_rvalid(host_rvalid), .host_rd_data(host_rd_data)
  );

  ram_arbiter ram_arbiter_i (
    .clk(clk), .rst(rst), .busy(busy), .eng_rd_addr(eng_rd_addr), .eng_wr(eng_wr),
    .host_rd(host_rd), .host_rd_addr(host_rd_addr), .host_wr(host_wr),
    .host_gnt(host_gnt), .host_rvalid(host_rvalid), .host_rd_data(host_rd_data),
    .ram_rd_addr(ram_rd_addr), .ram_wr(ram_wr), .ram_rd_data(ram_rd_data)
  );

  frame_ram frame_ram_i (
    .clk(clk), .rd_addr(ram_rd_addr), .rd_data(ram_rd_data), .wr(ram_wr)
  );

  pass_sequencer pass_sequencer_i (
    .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done), .pass(pass),
    .rd_addr(eng_rd_addr), .pix_valid(pix_valid), .wb_addr(wb_addr), .mean_calc(mean_calc)
  );

  pixel_ops pixel_ops_i (
    .clk(clk), .rst(rst), .start(start), .pass(pass), .pix_valid(pix_valid),
    .wb_addr(wb_addr), .mean_calc(mean_calc), .rd_data(ram_rd_data),
    .wr(eng_wr), .results(results)
  );

endmodule

`default_nettype wire

// File: tb/hand_seg_asserts.sv
// concurrent APB and buffer ownership checks bound into the engine top level
`timescale 1ns/1ps
`default_nettype none

module hand_seg_asserts (
  input logic                   clk,
  input logic                   rst,
  input hand_seg_pkg::apb_req_t apb_req,
  input hand_seg_pkg::apb_rsp_t apb_rsp,
  input logic                   busy,
  input logic                   done,
  input hand_seg_pkg::ram_wr_t  eng_wr
);

  int fail_count = 0;  // failed assertions so far

  // pready only ever ends an access phase
  pready_in_access: assert property (@(posedge clk) disable iff (!rst)
    apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else begin
      $error("pready high outside an APB access phase");
      fail_count++;
    end

  eng_write_owned: assert property (@(posedge clk) disable iff (!rst)
    eng_wr.we |-> busy)  // engine owns the buffer only while busy
    else begin
      $error("engine write enable while not busy");
      fail_count++;
    end

  busy_done_excl: assert property (@(posedge clk) disable iff (!rst)
    !(busy && done))
    else begin
      $error("busy and done high together");
      fail_count++;
    end

endmodule

bind hand_seg_top hand_seg_asserts asserts_i (
  .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
  .busy(busy), .done(done), .eng_wr(eng_wr)
);

`default_nettype wire

// File: tb/hand_seg_tb.sv
// self-checking testbench that loads frames over APB, runs the engine and compares with a model
`timescale 1ns/1ps
`default_nettype none

module hand_seg_tb;
  import hand_seg_pkg::*;

  typedef struct packed {
    logic   rand_fill;  // LCG pixels instead of the rectangle
    pixel_t fg;         // inside the rectangle
    pixel_t bg;
    int     x0, x1, y0, y1;
    int     exp_area;   // -1 when only the model knows
    int     exp_perim;
  } row_t;

  localparam pixel_t skin = '{r: 8'd200, g: 8'd150, b: 8'd130};
  localparam pixel_t grey = '{r: 8'd110, g: 8'd110, b: 8'd110};
  localparam int n_rows = 4;
  localparam row_t rows [n_rows] = '{
    '{rand_fill: 1'b0, fg: 24'h0, bg: 24'h0, x0: 0, x1: 31, y0: 0, y1: 23,
      exp_area: 0, exp_perim: 0},
    '{rand_fill: 1'b0, fg: skin, bg: skin, x0: 0, x1: 31, y0: 0, y1: 23,
      exp_area: 768, exp_perim: 1},
    '{rand_fill: 1'b0, fg: skin, bg: grey, x0: 8, x1: 19, y0: 6, y1: 15,
      exp_area: 120, exp_perim: 20},
    '{rand_fill: 1'b1, fg: 24'h0, bg: 24'h0, x0: 0, x1: 0, y0: 0, y1: 0,
      exp_area: -1, exp_perim: -1}
  };
  // engine passes plus frame load, readback and mask read per row
  localparam int limit = n_rows * (5 * n_pix + 200) + n_rows * 10 * n_pix + 200;

  logic        clk;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  pixel_t      frame [n_pix];
  pixel_t      mask  [n_pix];
  means_t      exp_means;
  count_t      exp_area, exp_perim;
  logic [31:0] lcg_state;

  hand_seg_top dut_i (.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (limit) @(posedge clk);
    $display("timeout: no APB completion or engine done within %0d cycles", limit);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  // any failed bound assertion ends the run
  initial begin
    wait (dut_i.asserts_i.fail_count != 0);
    $display("a bound assertion failed, see the error above");
    stop_run();
  end

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_means(input string name, input means_t got, input means_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // starts and returns 2 ns after a rising edge
  task automatic apb_xfer(input logic [paddr_w-1:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: wdata};
    @(posedge clk);
    #2 apb_req.penable = 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) @(negedge clk);  // sampled mid-cycle
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #2 apb_req = '0;
  endtask

  task automatic apb_write(input logic [paddr_w-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(addr, 1'b1, data, rd, err);
    check_flag("pslverr on write", err, 1'b0);
  endtask

  task automatic apb_read(input logic [paddr_w-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(addr, 1'b0, 32'd0, data, err);
    check_flag("pslverr on read", err, 1'b0);
  endtask

  task automatic build_frame(input row_t row);
    int x, y;
    for (int i = 0; i < n_pix; i++) begin
      x = i % img_w;
      y = i / img_w;
      if (row.rand_fill) begin
        lcg_state = lcg_next(lcg_state);
        frame[i]  = pixel_t'(lcg_state[31:8]);
      end else if (x >= row.x0 && x <= row.x1 && y >= row.y0 && y <= row.y1) begin
        frame[i] = row.fg;
      end else begin
        frame[i] = row.bg;
      end
    end
  endtask

  // means, compensation, chroma window, then area and red-edge count
  task automatic run_model();
    int sum_r, sum_g, sum_b, mr, mg, mb, mx;
    int rv, gv, bv, cb, cr;
    logic [7:0] prev;
    sum_r = 0;
    sum_g = 0;
    sum_b = 0;
    for (int i = 0; i < n_pix; i++) begin
      sum_r += int'(frame[i].r);
      sum_g += int'(frame[i].g);
      sum_b += int'(frame[i].b);
    end
    mr = sum_r / n_pix;
    mg = sum_g / n_pix;
    mb = sum_b / n_pix;
    mx = mr;
    if (mg > mx) mx = mg;
    if (mb > mx) mx = mb;
    exp_means = '{max_mean: 8'(mx), b: 8'(mb), g: 8'(mg), r: 8'(mr)};
    exp_area  = '0;
    exp_perim = '0;
    prev      = 8'd0;
    for (int i = 0; i < n_pix; i++) begin
      rv = (mx == 0) ? 0 : int'(frame[i].r) * mr / mx;
      gv = (mx == 0) ? 0 : int'(frame[i].g) * mg / mx;
      bv = (mx == 0) ? 0 : int'(frame[i].b) * mb / mx;
      cb = (128 + ((112 * bv - 38 * rv - 74 * gv) >>> 8)) & 255;
      cr = (128 + ((112 * rv - 94 * gv - 18 * bv) >>> 8)) & 255;
      if (cb >= int'(cb_lo) && cb <= int'(cb_hi) && cr >= int'(cr_lo) && cr <= int'(cr_hi))
        mask[i] = '{r: mask_on, g: mask_on, b: mask_on};
      else
        mask[i] = '0;
      if (mask[i] != '0) exp_area = exp_area + 1'b1;
      if (mask[i].r != prev) exp_perim = exp_perim + 1'b1;
      prev = mask[i].r;
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    time         t0;
    apb_req   = '0;
    rst       = 1'b0;
    lcg_state = 32'h3d8d;
    repeat (5) @(posedge clk);
    #2 rst = 1'b1;

    apb_read(reg_status, rd);
    check_flag("status.busy after reset", rd[0], 1'b0);
    check_flag("status.done after reset", rd[1], 1'b0);
    apb_read(reg_area, rd);
    check_count("area after reset", count_t'(rd[cnt_w-1:0]), '0);
    apb_read(reg_perim, rd);
    check_count("perim after reset", count_t'(rd[cnt_w-1:0]), '0);
    apb_read(reg_means, rd);
    check_means("means after reset", means_t'(rd), '0);

    // just past the frame and off the register map
    apb_xfer(frame_end, 1'b0, 32'd0, rd, err);
    check_flag("pslverr at frame end", err, 1'b1);
    apb_xfer(13'h1014, 1'b1, 32'd1, rd, err);
    check_flag("pslverr at 0x1014", err, 1'b1);

    for (int r = 0; r < n_rows; r++) begin
      build_frame(rows[r]);
      run_model();
      for (int i = 0; i < n_pix; i++)
        apb_write(paddr_w'(i * 4), {8'd0, frame[i]});
      for (int i = 0; i < n_pix; i++) begin
        apb_read(paddr_w'(i * 4), rd);
        check_pixel($sformatf("frame[%0d] before start", i), pixel_t'(rd[23:0]), frame[i]);
      end

      apb_write(reg_ctrl, 32'd1);
      t0 = $time;
      apb_read(reg_status, rd);
      check_flag("status.busy during run", rd[0], 1'b1);
      check_flag("status.done during run", rd[1], 1'b0);
      apb_read(paddr_w'(0), rd);  // held off until the engine lets go
      check_flag("frame read held while busy", ($time - t0) > time'(4 * n_pix * 20), 1'b1);
      check_pixel("mask[0] after held read", pixel_t'(rd[23:0]), mask[0]);
      apb_read(reg_status, rd);
      check_flag("status.busy after run", rd[0], 1'b0);
      check_flag("status.done after run", rd[1], 1'b1);

      apb_read(reg_means, rd);
      check_means($sformatf("means row %0d", r), means_t'(rd), exp_means);
      apb_read(reg_area, rd);
      check_count($sformatf("area row %0d", r), count_t'(rd[cnt_w-1:0]), exp_area);
      if (rows[r].exp_area >= 0)
        check_count("area vs table", count_t'(rd[cnt_w-1:0]), count_t'(rows[r].exp_area));
      apb_read(reg_perim, rd);
      check_count($sformatf("perim row %0d", r), count_t'(rd[cnt_w-1:0]), exp_perim);
      if (rows[r].exp_perim >= 0)
        check_count("perim vs table", count_t'(rd[cnt_w-1:0]), count_t'(rows[r].exp_perim));

      for (int i = 0; i < n_pix; i++) begin
        apb_read(paddr_w'(i * 4), rd);
        check_pixel($sformatf("mask[%0d] row %0d", i, r), pixel_t'(rd[23:0]), mask[i]);
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hand_seg_top.f
logic/hand_seg_pkg.sv
logic/frame_ram.sv
logic/ram_arbiter.sv
logic/apb_regs.sv
logic/pass_sequencer.sv
logic/pixel_ops.sv
logic/hand_seg_top.sv
tb/hand_seg_asserts.sv
tb/hand_seg_tb.sv

// File: run.sh
#!/bin/sh
# compile the testbench with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module hand_seg_tb -f hand_seg_top.f
out=$(./obj_dir/Vhand_seg_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
